//--- flist.f
+incdir+hdl
hdl/kpu_pkg.sv
hdl/control_logic.sv
hdl/register_file.sv
hdl/mlu.sv
hdl/shifter.sv
hdl/mmu.sv
hdl/kpu.sv
bench/kpu_checker.sv
bench/kpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= kpu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation gave no result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/kpu_tb.sv
`include "kpu_params.svh"

module kpu_tb import kpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        rst;
  kpu_opword_t op_in;
  logic        op_valid;
  logic        op_ready;
  kpu_wb_t     wb;
  logic        wb_valid;
  logic        wb_ready;
  int          check_count;
  int          error_count;
  int          outstanding;
  int          seed = 32'hf500_caaf;
  logic        ready_draw = 1'b0;
  logic        aborted;
  int          tests_run;
  int          errors_before;

  kpu u_kpu (
    .clk      (clk),
    .rst      (rst),
    .op_in    (op_in),
    .op_valid (op_valid),
    .wb_ready (wb_ready),
    .op_ready (op_ready),
    .wb       (wb),
    .wb_valid (wb_valid)
  );

  kpu_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .op_in       (op_in),
    .op_valid    (op_valid),
    .op_ready    (op_ready),
    .wb          (wb),
    .wb_valid    (wb_valid),
    .wb_ready    (wb_ready),
    .check_count (check_count),
    .error_count (error_count),
    .outstanding (outstanding)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int pick(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Consumer ready about 70 % of cycles, drawn on the rising edge
  always @(posedge clk) begin
    ready_draw = pick(10) < 7;
  end

  always @(negedge clk) begin
    wb_ready = ready_draw;
  end

  function automatic kpu_opword_t reg_op(input logic [5:0] code, input int d, input int a,
                                         input int b);
    kpu_opword_t w;
    w           = '0;
    w.opcode    = kpu_opcode_e'(code);
    w.f.r.dst   = d[4:0];
    w.f.r.src_a = a[4:0];
    w.f.r.src_b = b[4:0];
    return w;
  endfunction

  function automatic kpu_opword_t ldi_op(input int d, input int imm);
    kpu_opword_t w;
    w         = reg_op(OP_LDI, d, 0, 0);
    w.f.i.imm = imm[15:0];
    return w;
  endfunction

  // Called on a falling edge, returns on one
  task automatic send_op(input kpu_opword_t w);
    int waited;
    if (!aborted) begin
      op_in    = w;
      op_valid = 1'b1;
      waited   = 0;
      while (!op_ready && waited < 50) begin
        @(negedge clk);
        waited++;
      end
      if (!op_ready) begin
        $display("timeout: op_ready stayed low for 50 cycles");
        aborted = 1'b1;
      end else begin
        @(negedge clk);
      end
      op_valid = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (!aborted && !(op_ready && outstanding == 0) && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (!aborted && !(op_ready && outstanding == 0)) begin
      $display("timeout: write-back did not complete within 200 cycles");
      aborted = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    drain();
    tests_run++;
    $display("test %s: %s, write-backs checked %0d, new errors %0d", name,
             (error_count == errors_before && !aborted) ? "pass" : "fail",
             check_count, error_count - errors_before);
    errors_before = error_count;
  endtask

  initial begin
    rst           = 1'b1;
    op_in         = '0;
    op_valid      = 1'b0;
    wb_ready      = 1'b0;
    aborted       = 1'b0;
    tests_run     = 0;
    errors_before = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Known value in every register first
    for (int r = 0; r < `KPU_REGS; r++) begin
      send_op(ldi_op(r, pick(65536)));
    end
    repeat (16) send_op(ldi_op(pick(32), pick(65536)));
    end_test("ldi");

    // First one reads and writes the same register
    send_op(reg_op(OP_ADD, 5, 5, 9));
    repeat (40) send_op(reg_op(6'(int'(OP_ADD) + pick(5)), pick(32), pick(32), pick(32)));
    end_test("alu");

    // r29 = -5, shift amounts 0 and 31 from r30 and r31
    send_op(ldi_op(28, 5));
    send_op(ldi_op(30, 0));
    send_op(ldi_op(31, 31));
    send_op(reg_op(OP_SUB, 29, 30, 28));
    send_op(reg_op(OP_SAR, 27, 29, 31));
    send_op(reg_op(OP_SAR, 26, 29, 30));
    send_op(reg_op(OP_SHL, 25, 29, 31));
    send_op(reg_op(OP_SHR, 24, 29, 31));
    send_op(reg_op(OP_SHR, 23, 29, 30));
    repeat (30) send_op(reg_op(6'(int'(OP_SHL) + pick(3)), pick(32), pick(32), pick(32)));
    end_test("shift");

    // Addresses 0x10 and 0x11 written, 0xf0 left untouched
    send_op(ldi_op(1, 'h10));
    send_op(ldi_op(2, 'h11));
    send_op(ldi_op(3, pick(65536)));
    send_op(ldi_op(4, 'hf0));
    send_op(reg_op(OP_ST, 0, 1, 3));
    send_op(reg_op(OP_LD, 5, 1, 0));
    send_op(reg_op(OP_ST, 0, 2, 29));
    send_op(reg_op(OP_LD, 6, 2, 0));
    send_op(reg_op(OP_LD, 7, 1, 0));
    send_op(reg_op(OP_LD, 8, 4, 0));
    repeat (20) begin
      send_op(reg_op(OP_ST, 0, pick(32), pick(32)));
      send_op(reg_op(OP_LD, pick(32), pick(32), 0));
    end
    end_test("memory");

    // NOP or codes 12 to 63, then read every register back
    repeat (20) send_op(reg_op(6'(pick(2) == 0 ? 0 : 12 + pick(52)), pick(32), pick(32),
                               pick(32)));
    for (int r = 0; r < `KPU_REGS; r++) begin
      send_op(reg_op(OP_OR, r, r, r));
    end
    end_test("nop");

    // Any opcode under back-pressure, a few unused codes mixed in
    repeat (80) send_op(reg_op(6'(pick(14)), pick(32), pick(32), pick(32)));
    end_test("mixed");

    $display("tests %0d, write-backs checked %0d, errors %0d", tests_run, check_count,
             error_count);
    if (aborted || error_count != 0 || check_count == 0) begin
      $display("CHECKS FAILED");
    end else begin
      $display("ALL CHECKS PASSED");
    end
    $finish;
  end

endmodule

//--- bench/kpu_checker.sv
`include "kpu_params.svh"

module kpu_checker import kpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  kpu_opword_t op_in,
  input  logic        op_valid,
  input  logic        op_ready,
  input  kpu_wb_t     wb,
  input  logic        wb_valid,
  input  logic        wb_ready,
  output int          check_count,
  output int          error_count,
  output int          outstanding
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_BITS = $clog2(`KPU_MEM_WORDS);

  logic [`KPU_WIDTH-1:0] model_regs [`KPU_REGS];
  logic [`KPU_WIDTH-1:0] model_mem [`KPU_MEM_WORDS];
  kpu_wb_t               expect_q [$];
  kpu_wb_t               held_wb;
  logic                  stalled;

  // Sign fill built from a mask of the vacated upper bits
  function automatic logic [`KPU_WIDTH-1:0] shift_right_arith(
    input logic [`KPU_WIDTH-1:0] v,
    input logic [4:0]            n
  );
    logic [`KPU_WIDTH-1:0] fill;
    fill = v[`KPU_WIDTH-1] ? ~({`KPU_WIDTH{1'b1}} >> n) : '0;
    return (v >> n) | fill;
  endfunction

  // Model step for one accepted opword
  function automatic void predict(input kpu_opword_t w);
    logic [`KPU_WIDTH-1:0] a;
    logic [`KPU_WIDTH-1:0] b;
    logic [`KPU_WIDTH-1:0] res;
    logic                  has_wb;
    kpu_wb_t               entry;
    a      = model_regs[w.f.r.src_a];
    b      = model_regs[w.f.r.src_b];
    res    = '0;
    has_wb = 1'b1;
    case (w.opcode)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SHL:  res = a << b[4:0];
      OP_SHR:  res = a >> b[4:0];
      OP_SAR:  res = shift_right_arith(a, b[4:0]);
      OP_LDI:  res = {{(`KPU_WIDTH - 16){1'b0}}, w.f.i.imm};
      OP_LD:   res = model_mem[a[MEM_BITS-1:0]];
      OP_ST: begin
        model_mem[a[MEM_BITS-1:0]] = b;
        has_wb = 1'b0;
      end
      default: has_wb = 1'b0;
    endcase
    if (has_wb) begin
      entry.reg_idx = w.f.r.dst;
      entry.data    = res;
      expect_q.push_back(entry);
      model_regs[w.f.r.dst] = res;
    end
  endfunction

  function automatic void compare_wb();
    kpu_wb_t want;
    if (expect_q.size() == 0) begin
      $display("write-back to r%0d with data %08h arrived with no instruction outstanding",
               wb.reg_idx, wb.data);
      error_count++;
      return;
    end
    want = expect_q.pop_front();
    check_count++;
    if (wb.reg_idx !== want.reg_idx) begin
      $display("[ERROR] wb.reg got 0x%02h expected 0x%02h", wb.reg_idx, want.reg_idx);
      error_count++;
    end
    if (wb.data !== want.data) begin
      $display("[ERROR] wb.data got 0x%08h expected 0x%08h", wb.data, want.data);
      error_count++;
    end
  endfunction

  // Held write-back must survive a stall untouched
  function automatic void check_stall();
    if (!wb_valid) begin
      $display("wb_valid dropped while the write-back was stalled");
      error_count++;
    end else if (wb !== held_wb) begin
      $display("[ERROR] wb got 0x%h expected 0x%h during stall", wb, held_wb);
      error_count++;
    end
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `KPU_REGS; i++) begin
        model_regs[i] = '0;
      end
      for (int i = 0; i < `KPU_MEM_WORDS; i++) begin
        model_mem[i] = '0;
      end
      expect_q.delete();
      stalled     = 1'b0;
      check_count = 0;
      error_count = 0;
    end else begin
      if (stalled) begin
        check_stall();
      end
      if (wb_valid && wb_ready) begin
        compare_wb();
      end
      if (op_valid && op_ready) begin
        if (expect_q.size() != 0) begin
          $display("opword accepted while a write-back is still outstanding");
          error_count++;
        end
        predict(op_in);
      end
      stalled = wb_valid && !wb_ready;
      held_wb = wb;
    end
    outstanding = expect_q.size();
  end

endmodule

//--- hdl/kpu.sv
`include "kpu_params.svh"

module kpu import kpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  kpu_opword_t op_in,
  input  logic        op_valid,
  input  logic        wb_ready,
  output logic        op_ready,
  output kpu_wb_t     wb,
  output logic        wb_valid
);

  logic [`KPU_WIDTH-1:0] bus;
  logic [`KPU_WIDTH-1:0] reg_data;
  logic [`KPU_WIDTH-1:0] mlu_result;
  logic [`KPU_WIDTH-1:0] shift_result;
  logic [`KPU_WIDTH-1:0] mmu_data;
  logic [`KPU_WIDTH-1:0] tmp0;
  logic [`KPU_WIDTH-1:0] tmp1;
  kpu_opword_t           opword;
  kpu_ctrl_t             ctrl;

  control_logic u_control (
    .clk      (clk),
    .rst      (rst),
    .op_in    (op_in),
    .op_valid (op_valid),
    .wb_ready (wb_ready),
    .bus      (bus),
    .op_ready (op_ready),
    .opword   (opword),
    .ctrl     (ctrl),
    .wb       (wb),
    .wb_valid (wb_valid)
  );

  register_file u_regs (
    .clk      (clk),
    .rst      (rst),
    .opword   (opword),
    .reg_sel  (ctrl.reg_sel),
    .we       (ctrl.reg_we),
    .data_in  (bus),
    .data_out (reg_data)
  );

  // Scratch registers, not visible to programs
  always_ff @(posedge clk) begin
    if (rst) begin
      tmp0 <= '0;
      tmp1 <= '0;
    end else begin
      if (ctrl.tmp0_we) begin
        tmp0 <= bus;
      end
      if (ctrl.tmp1_we) begin
        tmp1 <= bus;
      end
    end
  end

  mlu u_mlu (
    .a      (tmp0),
    .b      (tmp1),
    .op     (ctrl.mlu_op),
    .result (mlu_result)
  );

  // Shift amount is the low 5 bits of tmp1
  shifter u_shifter (
    .value  (tmp0),
    .amount (tmp1[4:0]),
    .op     (ctrl.shift_op),
    .result (shift_result)
  );

  mmu u_mmu (
    .clk      (clk),
    .rst      (rst),
    .addr     (tmp0),
    .we       (ctrl.mem_we),
    .data_in  (bus),
    .data_out (mmu_data)
  );

  // One driver per cycle, chosen by the sequencer
  always_comb begin
    case (ctrl.bus_src)
      BUS_REG:     bus = reg_data;
      BUS_TMP0:    bus = tmp0;
      BUS_MLU:     bus = mlu_result;
      BUS_SHIFTER: bus = shift_result;
      BUS_MMU:     bus = mmu_data;
      BUS_IMM:     bus = {{(`KPU_WIDTH - 16){1'b0}}, opword.f.i.imm};
      default:     bus = '0;
    endcase
  end

endmodule

//--- hdl/mmu.sv
`include "kpu_params.svh"

module mmu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`KPU_WIDTH-1:0] addr,
  input  logic                  we,
  input  logic [`KPU_WIDTH-1:0] data_in,
  output logic [`KPU_WIDTH-1:0] data_out
);

  localparam int ADDR_BITS = $clog2(`KPU_MEM_WORDS);

  logic [`KPU_WIDTH-1:0] mem [`KPU_MEM_WORDS];
  logic [ADDR_BITS-1:0]  word;

  // Upper address bits are ignored
  assign word = addr[ADDR_BITS-1:0];

  assign data_out = mem[word];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `KPU_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[word] <= data_in;
    end
  end

  // Sequencer must keep stores off while in reset
  a_no_write_in_reset: assert property (@(posedge clk)
    rst |-> !we);

endmodule

//--- hdl/shifter.sv
`include "kpu_params.svh"

module shifter import kpu_pkg::*; (
  input  logic [`KPU_WIDTH-1:0] value,
  input  logic [4:0]            amount,
  input  shift_op_e             op,
  output logic [`KPU_WIDTH-1:0] result
);

  always_comb begin
    case (op)
      SH_SHL: begin
        result = value << amount;
      end
      SH_SHR: begin
        result = value >> amount;
      end
      SH_SAR: begin
        // Sign bit fills from the left
        result = $signed(value) >>> amount;
      end
      default: begin
        result = value;
      end
    endcase
  end

endmodule

//--- hdl/mlu.sv
`include "kpu_params.svh"

module mlu import kpu_pkg::*; (
  input  logic [`KPU_WIDTH-1:0] a,
  input  logic [`KPU_WIDTH-1:0] b,
  input  mlu_op_e               op,
  output logic [`KPU_WIDTH-1:0] result
);

  // Add and subtract wrap, carry out is dropped
  always_comb begin
    case (op)
      MLU_ADD: begin
        result = a + b;
      end
      MLU_SUB: begin
        result = a - b;
      end
      MLU_AND: begin
        result = a & b;
      end
      MLU_OR: begin
        result = a | b;
      end
      MLU_XOR: begin
        result = a ^ b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hdl/register_file.sv
`include "kpu_params.svh"

module register_file import kpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  kpu_opword_t           opword,
  input  reg_sel_e              reg_sel,
  input  logic                  we,
  input  logic [`KPU_WIDTH-1:0] data_in,
  output logic [`KPU_WIDTH-1:0] data_out
);

  logic [`KPU_WIDTH-1:0]    regs [`KPU_REGS];
  logic [`KPU_REG_BITS-1:0] idx;

  // Field of the opword that addresses the file
  always_comb begin
    case (reg_sel)
      SEL_SRC_A: idx = opword.f.r.src_a;
      SEL_SRC_B: idx = opword.f.r.src_b;
      default:   idx = opword.f.r.dst;
    endcase
  end

  assign data_out = regs[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `KPU_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[idx] <= data_in;
    end
  end

  // Only the destination field may be written
  a_write_dst: assert property (@(posedge clk) disable iff (rst)
    we |-> reg_sel == SEL_DST);

endmodule

//--- hdl/control_logic.sv
`include "kpu_params.svh"

module control_logic import kpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  kpu_opword_t           op_in,
  input  logic                  op_valid,
  input  logic                  wb_ready,
  input  logic [`KPU_WIDTH-1:0] bus,
  output logic                  op_ready,
  output kpu_opword_t           opword,
  output kpu_ctrl_t             ctrl,
  output kpu_wb_t               wb,
  output logic                  wb_valid
);

  kpu_state_e state;
  kpu_state_e state_next;
  logic       accept;

  assign op_ready = (state == S_FETCH);
  assign wb_valid = (state == S_WRITE);
  assign accept   = op_ready && op_valid;

  // Write-back carries whatever the bus holds in WRITE
  assign wb.reg_idx = opword.f.r.dst;
  assign wb.data    = bus;

  always_ff @(posedge clk) begin
    if (accept) begin
      opword <= op_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      S_FETCH: begin
        if (op_valid) begin
          case (op_in.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_SAR, OP_LD, OP_ST: state_next = S_LOAD_A;
            OP_LDI:                               state_next = S_WRITE;
            default:                              state_next = S_FETCH;
          endcase
        end
      end
      S_LOAD_A: begin
        case (opword.opcode)
          OP_LD:   state_next = S_WRITE;
          OP_ST:   state_next = S_STORE;
          default: state_next = S_LOAD_B;
        endcase
      end
      S_LOAD_B: state_next = S_WRITE;
      S_STORE:  state_next = S_FETCH;
      S_WRITE: begin
        // Hold until the write-back is taken
        if (wb_ready) begin
          state_next = S_FETCH;
        end
      end
      // EXEC is not entered by any opcode
      default:  state_next = S_FETCH;
    endcase
  end

  // Control plane
  always_comb begin
    ctrl = '0;

    case (opword.opcode)
      OP_SUB:  ctrl.mlu_op = MLU_SUB;
      OP_AND:  ctrl.mlu_op = MLU_AND;
      OP_OR:   ctrl.mlu_op = MLU_OR;
      OP_XOR:  ctrl.mlu_op = MLU_XOR;
      default: ctrl.mlu_op = MLU_ADD;
    endcase

    case (opword.opcode)
      OP_SHR:  ctrl.shift_op = SH_SHR;
      OP_SAR:  ctrl.shift_op = SH_SAR;
      default: ctrl.shift_op = SH_SHL;
    endcase

    case (state)
      S_LOAD_A: begin
        ctrl.bus_src = BUS_REG;
        ctrl.reg_sel = SEL_SRC_A;
        ctrl.tmp0_we = 1'b1;
      end
      S_LOAD_B: begin
        ctrl.bus_src = BUS_REG;
        ctrl.reg_sel = SEL_SRC_B;
        ctrl.tmp1_we = 1'b1;
      end
      S_STORE: begin
        // Address already sits in tmp0
        ctrl.bus_src = BUS_REG;
        ctrl.reg_sel = SEL_SRC_B;
        ctrl.mem_we  = 1'b1;
      end
      S_WRITE: begin
        ctrl.reg_sel = SEL_DST;
        ctrl.reg_we  = wb_ready;
        case (opword.opcode)
          OP_SHL, OP_SHR, OP_SAR: ctrl.bus_src = BUS_SHIFTER;
          OP_LDI:                 ctrl.bus_src = BUS_IMM;
          OP_LD:                  ctrl.bus_src = BUS_MMU;
          default:                ctrl.bus_src = BUS_MLU;
        endcase
      end
      default: ctrl.bus_src = BUS_NONE;
    endcase
  end

  // A stalled write-back must not change under the consumer
  a_wb_stable: assert property (@(posedge clk) disable iff (rst)
    wb_valid && !wb_ready |=> wb_valid && $stable(wb));

endmodule

//--- hdl/kpu_pkg.sv
`include "kpu_params.svh"

package kpu_pkg;

  // Unlisted codes decode as NOP
  typedef enum logic [5:0] {
    OP_NOP = 6'd0,
    OP_ADD = 6'd1,
    OP_SUB = 6'd2,
    OP_AND = 6'd3,
    OP_OR  = 6'd4,
    OP_XOR = 6'd5,
    OP_SHL = 6'd6,
    OP_SHR = 6'd7,
    OP_SAR = 6'd8,
    OP_LDI = 6'd9,
    OP_LD  = 6'd10,
    OP_ST  = 6'd11
  } kpu_opcode_e;

  typedef enum logic [2:0] {
    S_FETCH, S_LOAD_A, S_LOAD_B, S_EXEC, S_STORE, S_WRITE
  } kpu_state_e;

  typedef enum logic [2:0] {
    BUS_NONE, BUS_REG, BUS_TMP0, BUS_MLU, BUS_SHIFTER, BUS_MMU, BUS_IMM
  } bus_src_e;

  typedef enum logic [1:0] {
    SEL_DST   = 2'd0,
    SEL_SRC_A = 2'd1,
    SEL_SRC_B = 2'd2
  } reg_sel_e;

  typedef enum logic [2:0] {MLU_ADD, MLU_SUB, MLU_AND, MLU_OR, MLU_XOR} mlu_op_e;

  typedef enum logic [1:0] {SH_SHL, SH_SHR, SH_SAR} shift_op_e;

  // Register form of the operand fields
  typedef struct packed {
    logic [10:0]             rsvd;
    logic [`KPU_REG_BITS-1:0] src_b;
    logic [`KPU_REG_BITS-1:0] src_a;
    logic [`KPU_REG_BITS-1:0] dst;
  } kpu_reg_fields_t;

  // Immediate form, imm overlays src_b
  typedef struct packed {
    logic [15:0]             imm;
    logic [`KPU_REG_BITS-1:0] src_a;
    logic [`KPU_REG_BITS-1:0] dst;
  } kpu_imm_fields_t;

  typedef union packed {
    kpu_reg_fields_t r;
    kpu_imm_fields_t i;
  } kpu_fields_u;

  typedef struct packed {
    kpu_fields_u f;
    kpu_opcode_e opcode;
  } kpu_opword_t;

  typedef struct packed {
    bus_src_e  bus_src;
    reg_sel_e  reg_sel;
    logic      reg_we;
    logic      tmp0_we;
    logic      tmp1_we;
    logic      mem_we;
    mlu_op_e   mlu_op;
    shift_op_e shift_op;
  } kpu_ctrl_t;

  typedef struct packed {
    logic [`KPU_REG_BITS-1:0] reg_idx;
    logic [`KPU_WIDTH-1:0]    data;
  } kpu_wb_t;

endpackage

//--- hdl/kpu_params.svh
`ifndef KPU_PARAMS_SVH
`define KPU_PARAMS_SVH

// Bus and data path width
`define KPU_WIDTH 32

// General register file
`define KPU_REGS 32
`define KPU_REG_BITS 5

// Data memory depth in words, indexed by the low bits of tmp0
`define KPU_MEM_WORDS 256

`endif
